// File: hdl/dual_issue_pkg.sv
/* dual issue pipeline definitions */
package dual_issue_pkg;

    // widths
    localparam int addr_width = 8;
    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi = 6'h08;
    localparam logic [5:0] op_andi = 6'h0c;
    localparam logic [5:0] op_ori = 6'h0d;

    // funct field of r-type words
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;

    localparam logic [addr_width-1:0] reset_pc = '0;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    // one instruction word, seen as r or i format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [reg_addr_width-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fields;
        struct packed {
            logic [5:0] opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [15:0] imm16;
        } i_fields;
    } instr_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        instr_t instr_a;
        instr_t instr_b;
        logic valid_a;
        logic valid_b;
    } fetch_packet_t;

    typedef struct packed {
        logic valid;
        logic reg_write;
        logic alu_src_imm;
        logic zero_ext;
        alu_op_t alu_op;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] dest;
        logic [4:0] shamt;
        logic [data_width-1:0] immediate;
    } lane_ctrl_t;

    typedef struct packed {
        lane_ctrl_t ctrl;
        logic [data_width-1:0] rs_data;
        logic [data_width-1:0] rt_data;
    } lane_exec_t;

    // committed write, also the write port and forwarding source
    typedef struct packed {
        logic valid;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0] data;
    } retire_t;

endpackage

// File: hdl/fetch_unit.sv
/* pair fetch and fetch/decode register */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     split,
    input  dual_issue_pkg::instr_t                   fetch_instr_a,
    input  dual_issue_pkg::instr_t                   fetch_instr_b,
    output logic [dual_issue_pkg::addr_width-1:0]    fetch_pc,
    output dual_issue_pkg::fetch_packet_t            packet
);

    // one word consumed on a split, two otherwise
    always_ff @(posedge clk)
    begin
        if (!reset)
            fetch_pc <= dual_issue_pkg::reset_pc;
        else
            fetch_pc <= fetch_pc + (split ? 2'd1 : 2'd2);
    end

    // on a split the held-back lane b moves up to lane a
    always_ff @(posedge clk)
    begin
        if (split)
        begin
            packet.pc <= packet.pc + 1'b1;
            packet.instr_a <= packet.instr_b;
            packet.instr_b <= fetch_instr_a;
        end
        else
        begin
            packet.pc <= fetch_pc;
            packet.instr_a <= fetch_instr_a;
            packet.instr_b <= fetch_instr_b;
        end
        packet.valid_a <= reset;
        packet.valid_b <= reset;
    end

    // a valid packet stays two words behind the fetch pc
    pc_align_check: assert property (
        @(posedge clk) disable iff (!reset)
        packet.valid_a |-> fetch_pc - packet.pc == 2'd2
    );

endmodule

// File: hdl/decode_unit.sv
/* decode and in-packet hazard check */
`timescale 1ns/100ps

module decode_unit (
    input  logic                                         clk,
    input  logic                                         reset,
    input  dual_issue_pkg::fetch_packet_t                packet,
    output logic [dual_issue_pkg::reg_addr_width-1:0]    rd_index [4],
    input  logic [dual_issue_pkg::data_width-1:0]        rd_data [4],
    output logic                                         split,
    output dual_issue_pkg::lane_exec_t                   exec_a,
    output dual_issue_pkg::lane_exec_t                   exec_b
);

    dual_issue_pkg::lane_ctrl_t ctrl_a;
    dual_issue_pkg::lane_ctrl_t ctrl_b;
    logic b_is_rtype;

    function automatic dual_issue_pkg::lane_ctrl_t decode_lane(
        input dual_issue_pkg::instr_t word,
        input logic valid
    );
        dual_issue_pkg::lane_ctrl_t ctrl;
        ctrl = '0;
        ctrl.valid = valid;
        ctrl.reg_write = 1'b1;
        // rs and rt sit at the same bits in both formats
        ctrl.rs = word.r_fields.rs;
        ctrl.rt = word.r_fields.rt;
        if (word.r_fields.opcode == dual_issue_pkg::op_rtype)
        begin
            ctrl.dest = word.r_fields.rd;
            ctrl.shamt = word.r_fields.shamt;
            case (word.r_fields.funct)
                dual_issue_pkg::fn_add: ctrl.alu_op = dual_issue_pkg::alu_add;
                dual_issue_pkg::fn_sub: ctrl.alu_op = dual_issue_pkg::alu_sub;
                dual_issue_pkg::fn_and: ctrl.alu_op = dual_issue_pkg::alu_and;
                dual_issue_pkg::fn_or: ctrl.alu_op = dual_issue_pkg::alu_or;
                dual_issue_pkg::fn_xor: ctrl.alu_op = dual_issue_pkg::alu_xor;
                dual_issue_pkg::fn_slt: ctrl.alu_op = dual_issue_pkg::alu_slt;
                dual_issue_pkg::fn_sll: ctrl.alu_op = dual_issue_pkg::alu_sll;
                dual_issue_pkg::fn_srl: ctrl.alu_op = dual_issue_pkg::alu_srl;
                default: ctrl.reg_write = 1'b0;
            endcase
        end
        else
        begin
            ctrl.dest = word.i_fields.rt;
            ctrl.alu_src_imm = 1'b1;
            case (word.i_fields.opcode)
                dual_issue_pkg::op_addi: ctrl.alu_op = dual_issue_pkg::alu_add;
                dual_issue_pkg::op_andi:
                begin
                    ctrl.alu_op = dual_issue_pkg::alu_and;
                    ctrl.zero_ext = 1'b1;
                end
                dual_issue_pkg::op_ori:
                begin
                    ctrl.alu_op = dual_issue_pkg::alu_or;
                    ctrl.zero_ext = 1'b1;
                end
                default: ctrl.reg_write = 1'b0;
            endcase
            ctrl.immediate = {{(dual_issue_pkg::data_width-16){
                !ctrl.zero_ext && word.i_fields.imm16[15]}}, word.i_fields.imm16};
        end
        // no write to the hardwired r0
        if (ctrl.dest == '0)
            ctrl.reg_write = 1'b0;
        return ctrl;
    endfunction

    always_comb
    begin
        ctrl_a = decode_lane(packet.instr_a, packet.valid_a);
        ctrl_b = decode_lane(packet.instr_b, packet.valid_b);
    end

    assign rd_index[0] = ctrl_a.rs;
    assign rd_index[1] = ctrl_a.rt;
    assign rd_index[2] = ctrl_b.rs;
    assign rd_index[3] = ctrl_b.rt;

    // rt is only a source for r-type
    assign b_is_rtype = packet.instr_b.r_fields.opcode == dual_issue_pkg::op_rtype;
    assign split = ctrl_a.valid && ctrl_a.reg_write && ctrl_b.valid &&
                   (ctrl_a.dest == ctrl_b.rs || (b_is_rtype && ctrl_a.dest == ctrl_b.rt));

    always_ff @(posedge clk)
    begin
        exec_a <= '{ctrl: ctrl_a, rs_data: rd_data[0], rt_data: rd_data[1]};
        exec_b <= '{ctrl: ctrl_b, rs_data: rd_data[2], rt_data: rd_data[3]};
        // lane b of a split pair comes back next cycle as lane a
        exec_b.ctrl.valid <= ctrl_b.valid && !split;
        if (!reset)
        begin
            exec_a.ctrl.valid <= 1'b0;
            exec_b.ctrl.valid <= 1'b0;
        end
    end

    // held-back lane b arrives as the next lane a
    split_refetches_b: assert property (
        @(posedge clk) disable iff (!reset)
        split |=> packet.instr_a == $past(packet.instr_b)
    );

endmodule

// File: hdl/register_file.sv
/* 2 write 4 read register file */
`timescale 1ns/100ps

module register_file (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [dual_issue_pkg::reg_addr_width-1:0]    rd_index [4],
    output logic [dual_issue_pkg::data_width-1:0]        rd_data [4],
    input  dual_issue_pkg::retire_t                      retire_a,
    input  dual_issue_pkg::retire_t                      retire_b
);

    logic [dual_issue_pkg::data_width-1:0] regs [dual_issue_pkg::reg_count];

    // lane b written last so it wins on the same dest
    always_ff @(posedge clk)
    begin
        if (!reset)
            regs <= '{default: '0};
        else
        begin
            if (retire_a.valid)
                regs[retire_a.dest] <= retire_a.data;
            if (retire_b.valid)
                regs[retire_b.dest] <= retire_b.data;
        end
    end

    // write-through, newest value first
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (retire_b.valid && retire_b.dest == rd_index[i])
                rd_data[i] = retire_b.data;
            else if (retire_a.valid && retire_a.dest == rd_index[i])
                rd_data[i] = retire_a.data;
            else
                rd_data[i] = regs[rd_index[i]];
        end
    end

    no_r0_write: assert property (
        @(posedge clk) disable iff (!reset)
        !(retire_a.valid && retire_a.dest == '0) && !(retire_b.valid && retire_b.dest == '0)
    );

endmodule

// File: hdl/execute_unit.sv
/* forwarding, alus and write-back register */
`timescale 1ns/100ps

module execute_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  dual_issue_pkg::lane_exec_t    exec_a,
    input  dual_issue_pkg::lane_exec_t    exec_b,
    output dual_issue_pkg::retire_t       retire_a,
    output dual_issue_pkg::retire_t       retire_b
);

    logic [dual_issue_pkg::data_width-1:0] result_a;
    logic [dual_issue_pkg::data_width-1:0] result_b;

    // retire_b is younger than retire_a
    function automatic logic [dual_issue_pkg::data_width-1:0] forward(
        input logic [dual_issue_pkg::reg_addr_width-1:0] index,
        input logic [dual_issue_pkg::data_width-1:0] reg_value,
        input dual_issue_pkg::retire_t older,
        input dual_issue_pkg::retire_t newer
    );
        if (newer.valid && newer.dest == index)
            return newer.data;
        else if (older.valid && older.dest == index)
            return older.data;
        return reg_value;
    endfunction

    function automatic logic [dual_issue_pkg::data_width-1:0] alu(
        input dual_issue_pkg::lane_exec_t lane,
        input dual_issue_pkg::retire_t older,
        input dual_issue_pkg::retire_t newer
    );
        logic [dual_issue_pkg::data_width-1:0] op_a;
        logic [dual_issue_pkg::data_width-1:0] op_b;
        logic [dual_issue_pkg::data_width-1:0] rt_value;
        logic [dual_issue_pkg::data_width-1:0] result;
        op_a = forward(lane.ctrl.rs, lane.rs_data, older, newer);
        rt_value = forward(lane.ctrl.rt, lane.rt_data, older, newer);
        op_b = lane.ctrl.alu_src_imm ? lane.ctrl.immediate : rt_value;
        case (lane.ctrl.alu_op)
            dual_issue_pkg::alu_add: result = op_a + op_b;
            dual_issue_pkg::alu_sub: result = op_a - op_b;
            dual_issue_pkg::alu_and: result = op_a & op_b;
            dual_issue_pkg::alu_or: result = op_a | op_b;
            dual_issue_pkg::alu_xor: result = op_a ^ op_b;
            dual_issue_pkg::alu_slt:
                result = {{(dual_issue_pkg::data_width-1){1'b0}},
                          $signed(op_a) < $signed(op_b)};
            // shifts work on rt
            dual_issue_pkg::alu_sll: result = op_b << lane.ctrl.shamt;
            dual_issue_pkg::alu_srl: result = op_b >> lane.ctrl.shamt;
            default: result = op_a + op_b;
        endcase
        return result;
    endfunction

    always_comb
    begin
        result_a = alu(exec_a, retire_a, retire_b);
        result_b = alu(exec_b, retire_a, retire_b);
    end

    always_ff @(posedge clk)
    begin
        retire_a.dest <= exec_a.ctrl.dest;
        retire_a.data <= result_a;
        retire_b.dest <= exec_b.ctrl.dest;
        retire_b.data <= result_b;
        if (!reset)
        begin
            retire_a.valid <= 1'b0;
            retire_b.valid <= 1'b0;
        end
        else
        begin
            retire_a.valid <= exec_a.ctrl.valid && exec_a.ctrl.reg_write;
            retire_b.valid <= exec_b.ctrl.valid && exec_b.ctrl.reg_write;
        end
    end

endmodule

// File: hdl/dual_issue_core.sv
/* dual issue core top */
`timescale 1ns/100ps

module dual_issue_core (
    input  logic                                     clk,
    input  logic                                     reset,
    output logic [dual_issue_pkg::addr_width-1:0]    fetch_pc,
    input  dual_issue_pkg::instr_t                   fetch_instr_a,
    input  dual_issue_pkg::instr_t                   fetch_instr_b,
    output dual_issue_pkg::retire_t                  retire_a,
    output dual_issue_pkg::retire_t                  retire_b
);

    dual_issue_pkg::fetch_packet_t packet;
    dual_issue_pkg::lane_exec_t exec_a;
    dual_issue_pkg::lane_exec_t exec_b;
    logic split;
    logic [dual_issue_pkg::reg_addr_width-1:0] rd_index [4];
    logic [dual_issue_pkg::data_width-1:0] rd_data [4];

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .reset         (reset),
        .split         (split),
        .fetch_instr_a (fetch_instr_a),
        .fetch_instr_b (fetch_instr_b),
        .fetch_pc      (fetch_pc),
        .packet        (packet)
    );

    decode_unit decode_unit_i (
        .clk      (clk),
        .reset    (reset),
        .packet   (packet),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .split    (split),
        .exec_a   (exec_a),
        .exec_b   (exec_b)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .retire_a (retire_a),
        .retire_b (retire_b)
    );

    execute_unit execute_unit_i (
        .clk      (clk),
        .reset    (reset),
        .exec_a   (exec_a),
        .exec_b   (exec_b),
        .retire_a (retire_a),
        .retire_b (retire_b)
    );

endmodule

// File: dv/issue_model.svh
/* in-order reference model */
`ifndef issue_model_svh
`define issue_model_svh

typedef struct packed {
    int due_cycle;
    logic [4:0] dest;
    logic [31:0] data;
} write_entry_t;

logic [31:0] model_regs [32];
write_entry_t expected_writes [$];

// register written by a word, 0 when it writes nothing
function automatic logic [4:0] write_dest(input dual_issue_pkg::instr_t word);
    if (word.r_fields.opcode == dual_issue_pkg::op_rtype)
        return (word.r_fields.funct inside {dual_issue_pkg::fn_add, dual_issue_pkg::fn_sub,
            dual_issue_pkg::fn_and, dual_issue_pkg::fn_or, dual_issue_pkg::fn_xor,
            dual_issue_pkg::fn_slt, dual_issue_pkg::fn_sll, dual_issue_pkg::fn_srl})
            ? word.r_fields.rd : 5'd0;
    if (word.i_fields.opcode inside {dual_issue_pkg::op_addi, dual_issue_pkg::op_andi,
        dual_issue_pkg::op_ori})
        return word.i_fields.rt;
    return 5'd0;
endfunction

// second word reads what the first one writes
function automatic logic pair_splits(input dual_issue_pkg::instr_t word_a,
                                     input dual_issue_pkg::instr_t word_b);
    logic [4:0] dest;
    dest = write_dest(word_a);
    return dest != 5'd0 && (word_b.r_fields.rs == dest ||
        (word_b.r_fields.opcode == dual_issue_pkg::op_rtype && word_b.r_fields.rt == dest));
endfunction

task automatic issue_word(input dual_issue_pkg::instr_t word, input int due);
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_zext;
    logic [31:0] result;
    write_entry_t entry;
    rs_val = model_regs[word.r_fields.rs];
    rt_val = model_regs[word.r_fields.rt];
    imm_zext = {16'h0, word.i_fields.imm16};
    case (word.r_fields.opcode)
        dual_issue_pkg::op_addi:
            result = rs_val + {{16{word.i_fields.imm16[15]}}, word.i_fields.imm16};
        dual_issue_pkg::op_andi: result = rs_val & imm_zext;
        dual_issue_pkg::op_ori: result = rs_val | imm_zext;
        default:
            case (word.r_fields.funct)
                dual_issue_pkg::fn_add: result = rs_val + rt_val;
                dual_issue_pkg::fn_sub: result = rs_val - rt_val;
                dual_issue_pkg::fn_and: result = rs_val & rt_val;
                dual_issue_pkg::fn_or: result = rs_val | rt_val;
                dual_issue_pkg::fn_xor: result = rs_val ^ rt_val;
                dual_issue_pkg::fn_slt: result = {31'd0, $signed(rs_val) < $signed(rt_val)};
                dual_issue_pkg::fn_sll: result = rt_val << word.r_fields.shamt;
                dual_issue_pkg::fn_srl: result = rt_val >> word.r_fields.shamt;
                default: result = '0;
            endcase
    endcase
    if (write_dest(word) != 5'd0)
    begin
        model_regs[write_dest(word)] = result;
        entry = '{due, write_dest(word), result};
        expected_writes.push_back(entry);
    end
endtask

`endif

// File: dv/tb_dual_issue.sv
/* dual issue core testbench */
`timescale 1ns/100ps

module tb_dual_issue;

    localparam int prog_len = 120;
    localparam int cycle_limit = 600;

    logic clk;
    logic reset;
    logic [dual_issue_pkg::addr_width-1:0] fetch_pc;
    logic [dual_issue_pkg::addr_width-1:0] next_fetch_pc;
    dual_issue_pkg::instr_t fetch_instr_a;
    dual_issue_pkg::instr_t fetch_instr_b;
    dual_issue_pkg::retire_t retire_a;
    dual_issue_pkg::retire_t retire_b;
    dual_issue_pkg::instr_t imem [256];
    int cycle;
    int dec_pc;
    int error_count;
    int write_count;

    `include "issue_model.svh"

    dual_issue_core dual_issue_core_i (
        .clk           (clk),
        .reset         (reset),
        .fetch_pc      (fetch_pc),
        .fetch_instr_a (fetch_instr_a),
        .fetch_instr_b (fetch_instr_b),
        .retire_a      (retire_a),
        .retire_b      (retire_b)
    );

    // second word wraps at 256
    assign fetch_instr_a = imem[fetch_pc];
    assign fetch_instr_b = imem[fetch_pc + 8'd1];

    always #4 clk = ~clk;

    task automatic build_program();
        logic [5:0] functs [8];
        logic [5:0] opcodes [3];
        int pick;
        functs = '{dual_issue_pkg::fn_add, dual_issue_pkg::fn_sub, dual_issue_pkg::fn_and,
                   dual_issue_pkg::fn_or, dual_issue_pkg::fn_xor, dual_issue_pkg::fn_slt,
                   dual_issue_pkg::fn_sll, dual_issue_pkg::fn_srl};
        opcodes = '{dual_issue_pkg::op_addi, dual_issue_pkg::op_andi, dual_issue_pkg::op_ori};
        foreach (imem[i])
            imem[i] = '0;
        // registers 0 to 7 only, so dependencies are frequent
        for (int i = 0; i < prog_len; i++)
        begin
            pick = $urandom_range(10, 0);
            imem[i].r_fields.rs = 5'($urandom_range(7, 0));
            imem[i].r_fields.rt = 5'($urandom_range(7, 0));
            if (pick < 8)
            begin
                imem[i].r_fields.rd = 5'($urandom_range(7, 0));
                imem[i].r_fields.funct = functs[pick];
                if (pick >= 6)
                    imem[i].r_fields.shamt = 5'($urandom_range(31, 0));
            end
            else
            begin
                imem[i].i_fields.opcode = opcodes[pick - 8];
                imem[i].i_fields.imm16 = 16'($urandom());
            end
        end
    endtask

    task automatic check_retire(input dual_issue_pkg::retire_t seen, input string lane);
        write_entry_t entry;
        if (!seen.valid)
            return;
        if (expected_writes.size() == 0)
        begin
            $display("FAILED at %0t: extra write on lane %s to r%0d", $time, lane, seen.dest);
            error_count++;
            return;
        end
        entry = expected_writes.pop_front();
        write_count++;
        if (seen.dest != entry.dest || seen.data != entry.data)
        begin
            $display("FAILED at %0t: lane %s wrote r%0d = %h, expected r%0d = %h", $time,
                     lane, seen.dest, seen.data, entry.dest, entry.data);
            error_count++;
        end
        if (cycle != entry.due_cycle)
        begin
            $display("FAILED at %0t: lane %s write in cycle %0d, expected in cycle %0d",
                     $time, lane, cycle, entry.due_cycle);
            error_count++;
        end
    endtask

    // check this cycle, then issue the pair now in decode
    task automatic check_cycle();
        dual_issue_pkg::instr_t word_a;
        dual_issue_pkg::instr_t word_b;
        logic split;
        check_retire(retire_a, "a");
        check_retire(retire_b, "b");
        if (expected_writes.size() != 0 && expected_writes[0].due_cycle <= cycle)
        begin
            $display("FAILED at %0t: write to r%0d due in cycle %0d never came", $time,
                     expected_writes[0].dest, expected_writes[0].due_cycle);
            error_count++;
            expected_writes.delete(0);
        end
        if (fetch_pc != next_fetch_pc)
        begin
            $display("FAILED at %0t: fetch_pc %0d, expected %0d", $time, fetch_pc,
                     next_fetch_pc);
            error_count++;
        end
        word_a = imem[dec_pc % 256];
        word_b = imem[(dec_pc + 1) % 256];
        split = pair_splits(word_a, word_b);
        next_fetch_pc = fetch_pc + (split ? 8'd1 : 8'd2);
        // retire comes two cycles after decode
        issue_word(word_a, cycle + 2);
        if (!split)
            issue_word(word_b, cycle + 2);
        dec_pc += split ? 1 : 2;
    endtask

    initial
    begin
        void'($urandom(32'h15b1_eaa6));
        clk = 1'b0;
        reset = 1'b0;
        cycle = 0;
        dec_pc = 0;
        error_count = 0;
        write_count = 0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        build_program();
        repeat (2)
        begin
            @(posedge clk);
            @(negedge clk);
            if (fetch_pc != dual_issue_pkg::reset_pc || retire_a.valid || retire_b.valid)
            begin
                $display("FAILED at %0t: fetch_pc %0d or a retire strobe wrong in reset",
                         $time, fetch_pc);
                error_count++;
            end
        end
        reset = 1'b1;
        // packet in decode is still invalid, no split possible
        next_fetch_pc = fetch_pc + 8'd2;
        while (!(dec_pc >= prog_len && expected_writes.size() == 0) && cycle < cycle_limit)
        begin
            @(negedge clk);
            cycle++;
            check_cycle();
        end
        if (!(dec_pc >= prog_len && expected_writes.size() == 0))
        begin
            $display("timeout after %0d cycles with %0d writes still missing", cycle,
                     expected_writes.size());
            error_count++;
        end
        else
        begin
            // a few quiet cycles to catch extra writes
            repeat (3)
            begin
                @(negedge clk);
                cycle++;
                check_cycle();
            end
        end
        $display("%0d writes checked, %0d errors", write_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+dv
hdl/dual_issue_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/dual_issue_core.sv
dv/tb_dual_issue.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - files:
      - hdl/dual_issue_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/decode_unit.sv
      - hdl/register_file.sv
      - hdl/execute_unit.sv
      - hdl/dual_issue_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_dual_issue.sv
